//--- build.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_dmem.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

//--- hdl/rv_alu.sv
// Combinational ALU for the integer register and immediate instructions and lui
`include "rv_consts.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] i_a,
    input  logic [`RV_XLEN-1:0] i_b,
    input  rv_isa_pkg::alu_op_e i_op,
    output logic [`RV_XLEN-1:0] o_result
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // shifts use only the low bits of b
    assign shamt       = i_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb
    begin
        case (i_op)
            rv_isa_pkg::ALU_ADD:    o_result = i_a + i_b;
            rv_isa_pkg::ALU_SUB:    o_result = i_a - i_b;
            rv_isa_pkg::ALU_SLL:    o_result = i_a << shamt;
            rv_isa_pkg::ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_isa_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            rv_isa_pkg::ALU_SRL:    o_result = i_a >> shamt;
            rv_isa_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
            rv_isa_pkg::ALU_OR:     o_result = i_a | i_b;
            rv_isa_pkg::ALU_AND:    o_result = i_a & i_b;
            rv_isa_pkg::ALU_PASS_B: o_result = i_b;
            default:                o_result = '0;
        endcase
    end

endmodule

//--- hdl/rv_consts.svh
// Core sizing constants, included by the packages and RTL that need widths or depths
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define RV_XLEN 32

// register file size and index width
`define RV_REG_NUM 32
`define RV_REG_AW 5

// data memory, byte addressed, addresses wrap at the top
`define RV_DMEM_BYTES 128
`define RV_DMEM_AW 7

`endif

//--- hdl/rv_core.sv
// Top level of the execution core; connects sequencer, decoder, registers, ALU and memory
`include "rv_consts.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`RV_XLEN-1:0]  i_instr,
    input  logic                 i_instr_valid,
    output logic                 o_instr_ready,
    output rv_core_pkg::retire_t o_retire,
    output logic [`RV_XLEN-1:0]  o_instret
);

    rv_core_pkg::ctrl_t  ctrl;
    logic [`RV_XLEN-1:0] instr_q;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] rf_wdata;
    logic                rf_we;
    logic                mem_wr;
    logic                mem_rd;

    // second ALU operand
    assign alu_b = ctrl.src_imm ? imm : rs2_data;

    rv_sequencer rv_sequencer_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .i_ctrl        (ctrl),
        .i_alu_result  (alu_result),
        .i_load_data   (load_data),
        .o_instr_ready (o_instr_ready),
        .o_instr_q     (instr_q),
        .o_rf_we       (rf_we),
        .o_rf_wdata    (rf_wdata),
        .o_mem_wr      (mem_wr),
        .o_mem_rd      (mem_rd),
        .o_retire      (o_retire),
        .o_instret     (o_instret)
    );

    rv_decoder rv_decoder_inst (
        .i_instr (instr_q),
        .o_ctrl  (ctrl),
        .o_imm   (imm)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rstn     (rstn),
        .i_we     (rf_we),
        .i_waddr  (ctrl.rd),
        .i_wdata  (rf_wdata),
        .i_raddr1 (ctrl.rs1),
        .i_raddr2 (ctrl.rs2),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    rv_alu rv_alu_inst (
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .i_op     (ctrl.alu_op),
        .o_result (alu_result)
    );

    rv_dmem rv_dmem_inst (
        .clk     (clk),
        .rstn    (rstn),
        .i_wr    (mem_wr),
        .i_rd    (mem_rd),
        .i_addr  (alu_result[`RV_DMEM_AW-1:0]),
        .i_wdata (rs2_data),
        .i_size  (ctrl.mem_size),
        .o_rdata (load_data)
    );

endmodule

//--- hdl/rv_core_pkg.sv
// Core-level types passed between the decoder, sequencer and top level
`include "rv_consts.svh"

package rv_core_pkg;

    typedef struct packed {
        rv_isa_pkg::alu_op_e   alu_op;
        logic                  src_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        rv_isa_pkg::mem_size_e mem_size;
        logic                  illegal;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  illegal;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } retire_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_LOAD = 2'd2
    } seq_state_e;

endpackage

//--- hdl/rv_decoder.sv
// Combinational instruction decoder producing the control struct and the immediate
`include "rv_consts.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0] i_instr,
    output rv_core_pkg::ctrl_t  o_ctrl,
    output logic [`RV_XLEN-1:0] o_imm
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                unknown;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_sh;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i  = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s  = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u  = {i_instr[31:12], 12'b0};
    assign imm_sh = {{(`RV_XLEN-5){1'b0}}, i_instr[24:20]};

    always_comb
    begin
        o_ctrl          = '0;
        o_ctrl.alu_op   = rv_isa_pkg::ALU_ADD;
        o_ctrl.mem_size = rv_isa_pkg::MEM_WORD;
        o_ctrl.rs1      = i_instr[19:15];
        o_ctrl.rs2      = i_instr[24:20];
        o_ctrl.rd       = i_instr[11:7];
        o_imm           = imm_i;
        unknown         = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_REG:
            begin
                o_ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
                    10'b0100000_000: o_ctrl.alu_op = rv_isa_pkg::ALU_SUB;
                    10'b0000000_001: o_ctrl.alu_op = rv_isa_pkg::ALU_SLL;
                    10'b0000000_010: o_ctrl.alu_op = rv_isa_pkg::ALU_SLT;
                    10'b0000000_011: o_ctrl.alu_op = rv_isa_pkg::ALU_SLTU;
                    10'b0000000_100: o_ctrl.alu_op = rv_isa_pkg::ALU_XOR;
                    10'b0000000_101: o_ctrl.alu_op = rv_isa_pkg::ALU_SRL;
                    10'b0100000_101: o_ctrl.alu_op = rv_isa_pkg::ALU_SRA;
                    10'b0000000_110: o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    10'b0000000_111: o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    default:         unknown = 1'b1;
                endcase
            end
            rv_isa_pkg::OP_IMM:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.src_imm   = 1'b1;
                case (funct3)
                    3'b000: o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
                    3'b010: o_ctrl.alu_op = rv_isa_pkg::ALU_SLT;
                    3'b011: o_ctrl.alu_op = rv_isa_pkg::ALU_SLTU;
                    3'b100: o_ctrl.alu_op = rv_isa_pkg::ALU_XOR;
                    3'b110: o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    3'b111: o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    3'b001:
                    begin
                        o_ctrl.alu_op = rv_isa_pkg::ALU_SLL;
                        o_imm         = imm_sh;
                        unknown       = (funct7 != 7'b0000000);
                    end
                    default:
                    begin
                        // 101, srli or srai picked by funct7
                        o_ctrl.alu_op = (funct7[5]) ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                        o_imm         = imm_sh;
                        unknown       = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            rv_isa_pkg::OP_LOAD:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.src_imm   = 1'b1;
                case (funct3)
                    3'b000:  o_ctrl.mem_size = rv_isa_pkg::MEM_BYTE;
                    3'b001:  o_ctrl.mem_size = rv_isa_pkg::MEM_HALF;
                    3'b010:  o_ctrl.mem_size = rv_isa_pkg::MEM_WORD;
                    3'b100:  o_ctrl.mem_size = rv_isa_pkg::MEM_BYTE_U;
                    3'b101:  o_ctrl.mem_size = rv_isa_pkg::MEM_HALF_U;
                    default: unknown = 1'b1;
                endcase
            end
            rv_isa_pkg::OP_STORE:
            begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.src_imm   = 1'b1;
                o_imm            = imm_s;
                case (funct3)
                    3'b000:  o_ctrl.mem_size = rv_isa_pkg::MEM_BYTE;
                    3'b001:  o_ctrl.mem_size = rv_isa_pkg::MEM_HALF;
                    3'b010:  o_ctrl.mem_size = rv_isa_pkg::MEM_WORD;
                    default: unknown = 1'b1;
                endcase
            end
            rv_isa_pkg::OP_LUI:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.src_imm   = 1'b1;
                o_ctrl.alu_op    = rv_isa_pkg::ALU_PASS_B;
                o_imm            = imm_u;
            end
            default: unknown = 1'b1;
        endcase

        // nothing is written for an unrecognized word
        if (unknown)
        begin
            o_ctrl.illegal   = 1'b1;
            o_ctrl.reg_write = 1'b0;
            o_ctrl.mem_read  = 1'b0;
            o_ctrl.mem_write = 1'b0;
        end
        if (o_ctrl.rd == '0)
            o_ctrl.reg_write = 1'b0;
    end

    always_comb
    begin
        assert ($onehot0({o_ctrl.reg_write, o_ctrl.mem_write, o_ctrl.illegal}))
            else $error("decoder raised more than one of write, store and illegal");
    end

endmodule

//--- hdl/rv_dmem.sv
// Little-endian byte data memory with sized stores and a registered, extended load
`include "rv_consts.svh"

module rv_dmem (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_wr,
    input  logic                   i_rd,
    input  logic [`RV_DMEM_AW-1:0] i_addr,
    input  logic [`RV_XLEN-1:0]    i_wdata,
    input  rv_isa_pkg::mem_size_e  i_size,
    output logic [`RV_XLEN-1:0]    o_rdata
);

    logic [7:0]             mem [`RV_DMEM_BYTES];
    logic [`RV_DMEM_AW-1:0] addr1;
    logic [`RV_DMEM_AW-1:0] addr2;
    logic [`RV_DMEM_AW-1:0] addr3;
    logic [`RV_XLEN-1:0]    word;
    logic [`RV_XLEN-1:0]    load_ext;

    // byte addresses wrap around the top of memory
    assign addr1 = i_addr + 1'b1;
    assign addr2 = i_addr + 2'd2;
    assign addr3 = i_addr + 2'd3;
    assign word  = {mem[addr3], mem[addr2], mem[addr1], mem[i_addr]};

    always_comb
    begin
        case (i_size)
            rv_isa_pkg::MEM_BYTE:   load_ext = {{(`RV_XLEN-8){word[7]}}, word[7:0]};
            rv_isa_pkg::MEM_HALF:   load_ext = {{(`RV_XLEN-16){word[15]}}, word[15:0]};
            rv_isa_pkg::MEM_BYTE_U: load_ext = {{(`RV_XLEN-8){1'b0}}, word[7:0]};
            rv_isa_pkg::MEM_HALF_U: load_ext = {{(`RV_XLEN-16){1'b0}}, word[15:0]};
            default:                load_ext = word;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `RV_DMEM_BYTES; i++)
                mem[i] <= '0;
        end
        else if (i_wr)
        begin
            mem[i_addr] <= i_wdata[7:0];
            if (i_size != rv_isa_pkg::MEM_BYTE)
                mem[addr1] <= i_wdata[15:8];
            if (i_size == rv_isa_pkg::MEM_WORD)
            begin
                mem[addr2] <= i_wdata[23:16];
                mem[addr3] <= i_wdata[31:24];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rd)
            o_rdata <= load_ext;
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rstn) !(i_wr && i_rd))
        else $error("data memory read and write strobed together");

endmodule

//--- hdl/rv_isa_pkg.sv
// RV32I encodings shared by the decoder, ALU and data memory; referenced by scoped names
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // values follow funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_size_e;

endpackage

//--- hdl/rv_regfile.sv
// General purpose register file, two combinational reads and one clocked write
`include "rv_consts.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_we,
    input  logic [`RV_REG_AW-1:0] i_waddr,
    input  logic [`RV_XLEN-1:0]   i_wdata,
    input  logic [`RV_REG_AW-1:0] i_raddr1,
    input  logic [`RV_REG_AW-1:0] i_raddr2,
    output logic [`RV_XLEN-1:0]   o_rdata1,
    output logic [`RV_XLEN-1:0]   o_rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `RV_REG_NUM; i++)
                regs[i] <= '0;
        end
        // x0 is never written
        else if (i_we && (i_waddr != '0))
            regs[i_waddr] <= i_wdata;
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

    // reads of x0 rely on it staying zero
    a_x0_zero: assert property (@(posedge clk) disable iff (!rstn) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

//--- hdl/rv_sequencer.sv
// Instruction handshake FSM; steps execute and load, writes back, retires and counts
`include "rv_consts.svh"

module rv_sequencer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`RV_XLEN-1:0]  i_instr,
    input  logic                 i_instr_valid,
    input  rv_core_pkg::ctrl_t   i_ctrl,
    input  logic [`RV_XLEN-1:0]  i_alu_result,
    input  logic [`RV_XLEN-1:0]  i_load_data,
    output logic                 o_instr_ready,
    output logic [`RV_XLEN-1:0]  o_instr_q,
    output logic                 o_rf_we,
    output logic [`RV_XLEN-1:0]  o_rf_wdata,
    output logic                 o_mem_wr,
    output logic                 o_mem_rd,
    output rv_core_pkg::retire_t o_retire,
    output logic [`RV_XLEN-1:0]  o_instret
);

    rv_core_pkg::seq_state_e state;
    rv_core_pkg::seq_state_e state_nxt;
    rv_core_pkg::retire_t    retire_nxt;
    logic                    accept;
    logic                    done;

    assign o_instr_ready = (state == rv_core_pkg::ST_IDLE);
    assign accept        = i_instr_valid && o_instr_ready;

    // loads finish one state later than everything else
    assign done = ((state == rv_core_pkg::ST_EXEC) && !i_ctrl.mem_read)
               || (state == rv_core_pkg::ST_LOAD);

    assign o_mem_wr   = (state == rv_core_pkg::ST_EXEC) && i_ctrl.mem_write;
    assign o_mem_rd   = (state == rv_core_pkg::ST_EXEC) && i_ctrl.mem_read;
    assign o_rf_we    = done && i_ctrl.reg_write;
    assign o_rf_wdata = (state == rv_core_pkg::ST_LOAD) ? i_load_data : i_alu_result;

    always_comb
    begin
        retire_nxt.valid     = done;
        retire_nxt.reg_write = o_rf_we;
        retire_nxt.illegal   = done && i_ctrl.illegal;
        retire_nxt.rd        = o_rf_we ? i_ctrl.rd : '0;
        retire_nxt.data      = o_rf_we ? o_rf_wdata : '0;
    end

    always_comb
    begin
        case (state)
            rv_core_pkg::ST_IDLE:
                state_nxt = accept ? rv_core_pkg::ST_EXEC : rv_core_pkg::ST_IDLE;
            rv_core_pkg::ST_EXEC:
                state_nxt = i_ctrl.mem_read ? rv_core_pkg::ST_LOAD : rv_core_pkg::ST_IDLE;
            default:
                state_nxt = rv_core_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= rv_core_pkg::ST_IDLE;
            o_instr_q <= '0;
            o_retire  <= '0;
            o_instret <= '0;
        end
        else
        begin
            state    <= state_nxt;
            o_retire <= retire_nxt;
            if (accept)
                o_instr_q <= i_instr;
            if (done)
                o_instret <= o_instret + 1'b1;
        end
    end

    a_retire_pulse: assert property (@(posedge clk) disable iff (!rstn)
        o_retire.valid |=> !o_retire.valid)
        else $error("retire pulse lasted two cycles");

    // ready only comes back together with the retire of the previous instruction
    a_ready_retire: assert property (@(posedge clk) disable iff (!rstn)
        !o_instr_ready ##1 o_instr_ready |-> o_retire.valid)
        else $error("ready returned without a retirement");

endmodule

//--- run.sh
#!/bin/sh
# compile with Verilator and run the core testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f build.f

out=$(./obj_dir/Vtb_rv_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- testbench/tb_rv_core.sv
// Testbench for the execution core: directed instruction table, then an LFSR-driven random phase
`include "rv_consts.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam int RAND_COUNT = 40;
    localparam int CYCLE_NS   = 40;

    // one row per instruction with its expected retirement
    typedef struct packed {
        logic [31:0] instr;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ill;
    } row_t;

    logic                 clk;
    logic                 rstn;
    logic [`RV_XLEN-1:0]  instr;
    logic                 instr_valid;
    logic                 ready;
    rv_core_pkg::retire_t retire;
    logic [`RV_XLEN-1:0]  instret;

    row_t        rows[$];
    logic [31:0] model_regs [32];
    logic [7:0]  model_mem [`RV_DMEM_BYTES];
    logic [31:0] lfsr_state = 32'h3bcf8a33;
    bit          table_built = 0;
    bit          test_bad;
    int          tests = 0;
    int          failed = 0;
    int          errors = 0;
    int          sent = 0;

    rv_core rv_core_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_instr       (instr),
        .i_instr_valid (instr_valid),
        .o_instr_ready (ready),
        .o_retire      (retire),
        .o_instret     (instret)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic void add_row(input logic [31:0] w, input logic we, input logic [4:0] rd,
                                    input logic [31:0] data, input logic ill);
        row_t r;
        r.instr = w;
        r.we    = we;
        r.rd    = rd;
        r.data  = data;
        r.ill   = ill;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        // operands
        add_row(enc_u(20'hF0F0F, 1), 1, 1, 32'hF0F0F000, 0);
        add_row(enc_i(12'h123, 1, 0, 1, OPC_IMM), 1, 1, 32'hF0F0F123, 0);
        add_row(enc_i(12'd5, 0, 0, 2, OPC_IMM), 1, 2, 32'h00000005, 0);
        add_row(enc_i(12'hFFD, 0, 0, 3, OPC_IMM), 1, 3, 32'hFFFFFFFD, 0);
        // register-register
        add_row(enc_r(7'h00, 2, 1, 0, 4), 1, 4, 32'hF0F0F128, 0);
        add_row(enc_r(7'h20, 3, 2, 0, 5), 1, 5, 32'h00000008, 0);
        add_row(enc_r(7'h00, 2, 1, 1, 6), 1, 6, 32'h1E1E2460, 0);
        add_row(enc_r(7'h00, 2, 3, 2, 7), 1, 7, 32'h00000001, 0);
        add_row(enc_r(7'h00, 2, 3, 3, 8), 1, 8, 32'h00000000, 0);
        add_row(enc_r(7'h00, 3, 1, 4, 9), 1, 9, 32'h0F0F0EDE, 0);
        add_row(enc_r(7'h00, 2, 1, 5, 10), 1, 10, 32'h07878789, 0);
        add_row(enc_r(7'h20, 2, 1, 5, 11), 1, 11, 32'hFF878789, 0);
        add_row(enc_r(7'h00, 2, 1, 6, 12), 1, 12, 32'hF0F0F127, 0);
        add_row(enc_r(7'h00, 3, 1, 7, 13), 1, 13, 32'hF0F0F121, 0);
        // register-immediate
        add_row(enc_i(12'h000, 3, 2, 14, OPC_IMM), 1, 14, 32'h00000001, 0);
        add_row(enc_i(12'hFFF, 2, 3, 15, OPC_IMM), 1, 15, 32'h00000001, 0);
        add_row(enc_i(12'hFFF, 1, 4, 16, OPC_IMM), 1, 16, 32'h0F0F0EDC, 0);
        add_row(enc_i(12'h0F0, 2, 6, 17, OPC_IMM), 1, 17, 32'h000000F5, 0);
        add_row(enc_i(12'h0FF, 1, 7, 18, OPC_IMM), 1, 18, 32'h00000023, 0);
        add_row(enc_i(12'h01C, 2, 1, 19, OPC_IMM), 1, 19, 32'h50000000, 0);
        add_row(enc_i(12'h010, 1, 5, 20, OPC_IMM), 1, 20, 32'h0000F0F0, 0);
        add_row(enc_i(12'h410, 1, 5, 21, OPC_IMM), 1, 21, 32'hFFFFF0F0, 0);
        // writes to x0 are dropped
        add_row(enc_i(12'h001, 1, 0, 0, OPC_IMM), 0, 0, 32'h0, 0);
        add_row(enc_u(20'h12345, 0), 0, 0, 32'h0, 0);
        add_row(enc_r(7'h00, 0, 0, 0, 22), 1, 22, 32'h00000000, 0);
        // stores and loads around base 16
        add_row(enc_i(12'd16, 0, 0, 23, OPC_IMM), 1, 23, 32'h00000010, 0);
        add_row(enc_u(20'h8765A, 24), 1, 24, 32'h8765A000, 0);
        add_row(enc_i(12'h3C1, 24, 0, 24, OPC_IMM), 1, 24, 32'h8765A3C1, 0);
        add_row(enc_s(12'd0, 24, 23, 2), 0, 0, 32'h0, 0);
        add_row(enc_i(12'd0, 23, 2, 25, OPC_LOAD), 1, 25, 32'h8765A3C1, 0);
        add_row(enc_i(12'd0, 23, 0, 25, OPC_LOAD), 1, 25, 32'hFFFFFFC1, 0);
        add_row(enc_i(12'd0, 23, 4, 25, OPC_LOAD), 1, 25, 32'h000000C1, 0);
        add_row(enc_i(12'd2, 23, 1, 25, OPC_LOAD), 1, 25, 32'hFFFF8765, 0);
        add_row(enc_i(12'd2, 23, 5, 25, OPC_LOAD), 1, 25, 32'h00008765, 0);
        add_row(enc_i(12'd1, 23, 0, 25, OPC_LOAD), 1, 25, 32'hFFFFFFA3, 0);
        add_row(enc_i(12'd2, 23, 4, 25, OPC_LOAD), 1, 25, 32'h00000065, 0);
        add_row(enc_s(12'd4, 3, 23, 0), 0, 0, 32'h0, 0);
        add_row(enc_s(12'd6, 24, 23, 1), 0, 0, 32'h0, 0);
        add_row(enc_i(12'd4, 23, 2, 26, OPC_LOAD), 1, 26, 32'hA3C100FD, 0);
        add_row(enc_i(12'd6, 23, 1, 26, OPC_LOAD), 1, 26, 32'hFFFFA3C1, 0);
        add_row(enc_i(12'd6, 23, 5, 26, OPC_LOAD), 1, 26, 32'h0000A3C1, 0);
        add_row(enc_i(12'd4, 23, 0, 26, OPC_LOAD), 1, 26, 32'hFFFFFFFD, 0);
        add_row(enc_s(12'd1, 2, 23, 0), 0, 0, 32'h0, 0);
        add_row(enc_i(12'd0, 23, 2, 27, OPC_LOAD), 1, 27, 32'h876505C1, 0);
        // word at 126 wraps into bytes 0 and 1
        add_row(enc_s(12'd126, 24, 0, 2), 0, 0, 32'h0, 0);
        add_row(enc_i(12'd126, 0, 2, 28, OPC_LOAD), 1, 28, 32'h8765A3C1, 0);
        add_row(enc_i(12'd0, 0, 5, 28, OPC_LOAD), 1, 28, 32'h00008765, 0);
        add_row(enc_i(12'd127, 0, 4, 28, OPC_LOAD), 1, 28, 32'h000000A3, 0);
        add_row(enc_i(12'd127, 0, 1, 28, OPC_LOAD), 1, 28, 32'h000065A3, 0);
        // beq, jal, mul and a doubleword store are not part of the core
        add_row(32'h00108063, 0, 0, 32'h0, 1);
        add_row(32'h000000EF, 0, 0, 32'h0, 1);
        add_row(enc_r(7'h01, 2, 1, 0, 1), 0, 0, 32'h0, 1);
        add_row(enc_s(12'd0, 24, 0, 3), 0, 0, 32'h0, 1);
        add_row(enc_i(12'd0, 1, 0, 29, OPC_IMM), 1, 29, 32'hF0F0F123, 0);
        add_row(enc_i(12'd0, 0, 2, 30, OPC_LOAD), 1, 30, 32'h00008765, 0);
    endfunction

    // reference model update after a retirement
    function automatic void model_commit(input row_t r);
        logic [31:0] addr;
        logic [31:0] val;
        logic [6:0]  a;
        int          n;
        if (r.we && r.rd != 5'd0)
            model_regs[r.rd] = r.data;
        if (r.instr[6:0] == OPC_STORE && !r.ill)
        begin
            n = (r.instr[14:12] == 3'd0) ? 1 : (r.instr[14:12] == 3'd1) ? 2 : 4;
            addr = model_regs[r.instr[19:15]]
                 + {{20{r.instr[31]}}, r.instr[31:25], r.instr[11:7]};
            val = model_regs[r.instr[24:20]];
            a = addr[6:0];
            for (int k = 0; k < n; k++)
            begin
                model_mem[a] = val[7:0];
                val = val >> 8;
                a = a + 7'd1;
            end
        end
    endfunction

    // random addi, xori, slli, sw or lw with the model's expected retirement
    function automatic row_t random_row();
        row_t        r;
        logic [31:0] bits;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [6:0]  a;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          sel;
        bits = rand_bits(3);
        sel = int'(bits % 5);
        bits = rand_bits(5);
        rd = bits[4:0];
        bits = rand_bits(5);
        rs1 = bits[4:0];
        bits = rand_bits(5);
        rs2 = bits[4:0];
        bits = rand_bits(12);
        imm = bits[11:0];
        simm = {{20{imm[11]}}, imm};
        r = '0;
        r.we = (sel != 3) && (rd != 5'd0);
        case (sel)
            0:
            begin
                r.instr = enc_i(imm, rs1, 0, rd, OPC_IMM);
                r.data = model_regs[rs1] + simm;
            end
            1:
            begin
                r.instr = enc_i(imm, rs1, 4, rd, OPC_IMM);
                r.data = model_regs[rs1] ^ simm;
            end
            2:
            begin
                r.instr = enc_i({7'b0, imm[4:0]}, rs1, 1, rd, OPC_IMM);
                r.data = model_regs[rs1] << imm[4:0];
            end
            3:
                r.instr = enc_s(imm, rs2, rs1, 2);
            default:
            begin
                r.instr = enc_i(imm, rs1, 2, rd, OPC_LOAD);
                addr = model_regs[rs1] + simm;
                a = addr[6:0];
                for (int k = 0; k < 4; k++)
                begin
                    r.data[8*k +: 8] = model_mem[a];
                    a = a + 7'd1;
                end
            end
        endcase
        if (r.we)
            r.rd = rd;
        else
            r.data = '0;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            errors++;
            test_bad = 1;
        end
    endtask

    // starts and ends on a falling edge
    task automatic run_instr(input row_t r);
        int wait_n;
        int cycles;
        int exp_cycles;
        wait_n = 0;
        cycles = 0;
        exp_cycles = (r.instr[6:0] == OPC_LOAD && !r.ill) ? 3 : 2;
        test_bad = 0;
        tests++;
        while (!ready && wait_n < 20)
        begin
            @(negedge clk);
            wait_n++;
        end
        if (!ready)
        begin
            $display("test %0d: the core never raised ready", tests);
            errors++;
            test_bad = 1;
        end
        else
        begin
            instr = r.instr;
            instr_valid = 1'b1;
            @(negedge clk);
            instr_valid = 1'b0;
            sent++;
            cycles = 1;
            while (!retire.valid && cycles < 20)
            begin
                @(negedge clk);
                cycles++;
            end
            if (!retire.valid)
            begin
                $display("test %0d: no retire pulse within 20 cycles of acceptance", tests);
                errors++;
                test_bad = 1;
            end
            else
            begin
                check_val("retire latency", 32'(exp_cycles), 32'(cycles));
                check_val("o_retire.reg_write", 32'(r.we), 32'(retire.reg_write));
                check_val("o_retire.rd", 32'(r.rd), 32'(retire.rd));
                check_val("o_retire.data", r.data, retire.data);
                check_val("o_retire.illegal", 32'(r.ill), 32'(retire.illegal));
            end
        end
        if (test_bad)
            failed++;
        $display("test %0d instr %h %s", tests, r.instr, test_bad ? "mismatch" : "ok");
    endtask

    initial
    begin
        int limit_ns;
        wait (table_built);
        limit_ns = (rows.size() + RAND_COUNT) * 4 * CYCLE_NS + 2000;
        #(limit_ns * 1ns);
        $display("watchdog expired after %0d ns with the tests still running", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        rstn = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < `RV_DMEM_BYTES; i++)
            model_mem[i] = '0;
        build_table();
        table_built = 1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        test_bad = 0;
        tests++;
        check_val("o_instr_ready", 32'd1, 32'(ready));
        check_val("o_retire.valid", 32'd0, 32'(retire.valid));
        check_val("o_instret", 32'd0, instret);
        rstn = 1'b1;
        @(negedge clk);
        check_val("o_instr_ready", 32'd1, 32'(ready));
        check_val("o_retire.valid", 32'd0, 32'(retire.valid));
        if (test_bad)
            failed++;
        $display("test %0d reset %s", tests, test_bad ? "mismatch" : "ok");

        foreach (rows[i])
        begin
            run_instr(rows[i]);
            model_commit(rows[i]);
        end

        for (int i = 0; i < RAND_COUNT; i++)
        begin
            row_t r;
            r = random_row();
            run_instr(r);
            model_commit(r);
        end

        @(negedge clk);
        test_bad = 0;
        tests++;
        check_val("o_instret", 32'(sent), instret);
        if (test_bad)
            failed++;
        $display("test %0d retire count %s", tests, test_bad ? "mismatch" : "ok");

        $display("%0d tests, %0d passed, %0d failed, %0d checks failed",
                 tests, tests - failed, failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
